/* rs_pkg.sv */
package rs_pkg;

    localparam int PC_W         = 32;
    localparam int TAG_W        = 8;
    localparam int RS_DEPTH     = 16;
    localparam int ISSUE_WINDOW = 8;   // Slots from head that select may scan
    localparam int NUM_WAKE     = 4;

    typedef logic [$clog2(RS_DEPTH)-1:0] rs_idx_t;
    typedef logic [$clog2(RS_DEPTH):0]   rs_cnt_t;   // One extra bit to hold RS_DEPTH
    typedef logic [TAG_W-1:0]            tag_t;

    // One result broadcast
    typedef struct packed {
        logic valid;
        tag_t tag;
    } wakeup_t;

    // Dispatched operation as held in the station
    typedef struct packed {
        logic [PC_W-1:0] pc;
        tag_t            rd;
        tag_t            src1;
        tag_t            src2;
        logic            rdy1;
        logic            rdy2;
    } rs_entry_t;

    // Packet handed to the multiplier
    typedef struct packed {
        logic [PC_W-1:0] pc;
        tag_t            rd;
        tag_t            src1;
        tag_t            src2;
    } issue_t;

    // True when any valid wakeup bus carries the given tag
    function automatic logic tag_woken(
        input tag_t                     tag,
        input wakeup_t [NUM_WAKE-1:0]   wakeup
    );
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < NUM_WAKE; i++) begin
            if (wakeup[i].valid && wakeup[i].tag == tag) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // Merges the current broadcasts into both ready bits
    function automatic rs_entry_t apply_wakeup(
        input rs_entry_t                entry,
        input wakeup_t [NUM_WAKE-1:0]   wakeup
    );
        rs_entry_t woken;
        woken      = entry;
        woken.rdy1 = entry.rdy1 | tag_woken(entry.src1, wakeup);
        woken.rdy2 = entry.rdy2 | tag_woken(entry.src2, wakeup);
        return woken;
    endfunction

endpackage

/* rs_dispatch_stage.sv */
module rs_dispatch_stage
    import rs_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    flush,

    input  rs_entry_t               dispatch,
    input  logic                    dispatch_valid,
    output logic                    dispatch_ready,

    input  wakeup_t [NUM_WAKE-1:0]  wakeup,

    output rs_entry_t               stage_entry,
    output logic                    stage_valid,
    input  logic                    file_accept
);

    rs_entry_t stage_q;     // Held operation, ready bits as of last edge
    rs_entry_t captured;    // Incoming operation with this cycle's wakeups
    logic      take;

    // Room when empty or when the held entry leaves this cycle
    assign dispatch_ready = !stage_valid || file_accept;
    assign take           = dispatch_valid && dispatch_ready;

    // A broadcast in the capture cycle must not be missed
    always_comb begin
        captured = apply_wakeup(dispatch, wakeup);
    end

    // Forward view also sees this cycle's broadcasts
    always_comb begin
        stage_entry = apply_wakeup(stage_q, wakeup);
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            stage_valid <= 1'b0;
        end else if (take) begin
            stage_valid <= 1'b1;
        end else if (file_accept) begin
            stage_valid <= 1'b0;    // Moved into the entry file
        end
    end

    // Payload keeps collecting wakeups while it waits for the file
    always_ff @(posedge clk) begin
        if (take) begin
            stage_q <= captured;
        end else if (stage_valid) begin
            stage_q <= stage_entry;
        end
    end

endmodule

/* rs_entry_file.sv */
module rs_entry_file
    import rs_pkg::*;
(
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            flush,

    input  rs_entry_t                       stage_entry,
    input  logic                            stage_valid,
    output logic                            file_accept,

    input  wakeup_t [NUM_WAKE-1:0]          wakeup,

    input  logic                            pick_valid,
    input  rs_idx_t                         pick_idx,

    output rs_entry_t [RS_DEPTH-1:0]        slots,
    output logic [RS_DEPTH-1:0]             slot_busy,
    output rs_idx_t                         head
);

    rs_idx_t tail;
    rs_cnt_t count;     // Allocated slots, issued ones included until head passes
    logic    push;
    logic    pop;

    assign file_accept = (count != rs_cnt_t'(RS_DEPTH));
    assign push        = stage_valid && file_accept;

    // Head slot already issued, so it can be released
    assign pop = (count != '0) && !slot_busy[head];

    // Allocation, issue and head/tail bookkeeping
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            slot_busy <= '0;
            head      <= '0;
            tail      <= '0;
            count     <= '0;
        end else begin
            if (push) begin
                slot_busy[tail] <= 1'b1;
                tail            <= tail + 1'b1;
            end
            if (pick_valid) begin
                slot_busy[pick_idx] <= 1'b0;    // Issued this edge
            end
            if (pop) begin
                head <= head + 1'b1;            // Skips one hole per cycle
            end
            count <= count + rs_cnt_t'(push) - rs_cnt_t'(pop);
        end
    end

    // Slot contents and ready-bit updates
    always_ff @(posedge clk) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (slot_busy[i]) begin
                slots[i] <= apply_wakeup(slots[i], wakeup);
            end
        end
        // Tail slot is never busy while a push is possible
        if (push) begin
            slots[tail] <= stage_entry;
        end
    end

endmodule

/* rs_issue_select.sv */
module rs_issue_select
    import rs_pkg::*;
(
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        flush,

    input  rs_entry_t [RS_DEPTH-1:0]    slots,
    input  logic [RS_DEPTH-1:0]         slot_busy,
    input  rs_idx_t                     head,

    output logic                        pick_valid,
    output rs_idx_t                     pick_idx,

    output issue_t                      issue,
    output logic                        issue_valid
);

    rs_idx_t [ISSUE_WINDOW-1:0] win_idx;     // Slot index per window position
    logic [ISSUE_WINDOW-1:0]    win_ready;
    rs_entry_t                  picked;

    // Window positions wrap around the slot array
    always_comb begin
        for (int i = 0; i < ISSUE_WINDOW; i++) begin
            win_idx[i]   = head + rs_idx_t'(i);
            win_ready[i] = slot_busy[win_idx[i]]
                           && slots[win_idx[i]].rdy1
                           && slots[win_idx[i]].rdy2;
        end
    end

    // Downward scan so the position nearest head wins
    always_comb begin
        pick_valid = 1'b0;
        pick_idx   = head;
        for (int i = ISSUE_WINDOW - 1; i >= 0; i--) begin
            if (win_ready[i]) begin
                pick_valid = 1'b1;
                pick_idx   = win_idx[i];
            end
        end
    end

    assign picked = slots[pick_idx];

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= pick_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (pick_valid) begin
            issue.pc   <= picked.pc;
            issue.rd   <= picked.rd;
            issue.src1 <= picked.src1;
            issue.src2 <= picked.src2;
        end
    end

endmodule

/* mul_rs_top.sv */
module mul_rs_top
    import rs_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    flush,

    input  rs_entry_t               dispatch,
    input  logic                    dispatch_valid,
    output logic                    dispatch_ready,

    input  wakeup_t [NUM_WAKE-1:0]  wakeup,

    output issue_t                  issue,
    output logic                    issue_valid
);

    rs_entry_t                  stage_entry;
    logic                       stage_valid;
    logic                       file_accept;
    rs_entry_t [RS_DEPTH-1:0]   slots;
    logic [RS_DEPTH-1:0]        slot_busy;
    rs_idx_t                    head;
    logic                       pick_valid;
    rs_idx_t                    pick_idx;

    rs_dispatch_stage u_dispatch (
        .clk            (clk),
        .reset          (reset),
        .flush          (flush),
        .dispatch       (dispatch),
        .dispatch_valid (dispatch_valid),
        .dispatch_ready (dispatch_ready),
        .wakeup         (wakeup),
        .stage_entry    (stage_entry),
        .stage_valid    (stage_valid),
        .file_accept    (file_accept)
    );

    rs_entry_file u_file (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .stage_entry (stage_entry),
        .stage_valid (stage_valid),
        .file_accept (file_accept),
        .wakeup      (wakeup),
        .pick_valid  (pick_valid),
        .pick_idx    (pick_idx),
        .slots       (slots),
        .slot_busy   (slot_busy),
        .head        (head)
    );

    rs_issue_select u_select (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .slots       (slots),
        .slot_busy   (slot_busy),
        .head        (head),
        .pick_valid  (pick_valid),
        .pick_idx    (pick_idx),
        .issue       (issue),
        .issue_valid (issue_valid)
    );

endmodule

/* tb_mul_rs.sv */
module tb_mul_rs
    import rs_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD     = 20;
    localparam int NUM_OPS        = 27;     // Operations dispatched over all tests
    localparam int TIMEOUT_CYCLES = 20 * NUM_OPS + 200;
    localparam int NUM_FILL       = RS_DEPTH + 1;   // File plus the dispatch stage

    logic                   clk;
    logic                   reset;
    logic                   flush;
    rs_entry_t              dispatch;
    logic                   dispatch_valid;
    logic                   dispatch_ready;
    wakeup_t [NUM_WAKE-1:0] wakeup;
    issue_t                 issue;
    logic                   issue_valid;

    integer                 seed = 32'h37e0dd48;
    int                     cycle;
    int                     accept_cycle;   // Edge number of the last acceptance
    issue_t                 expected[$];
    int                     issue_cycles[$];
    issue_t                 exp_pkt;
    logic [2**TAG_W-1:0]    tag_used;       // Tags handed out as unready sources
    rs_entry_t              wait_ops[NUM_FILL];
    rs_entry_t              late_op;

    mul_rs_top dut (
        .clk            (clk),
        .reset          (reset),
        .flush          (flush),
        .dispatch       (dispatch),
        .dispatch_valid (dispatch_valid),
        .dispatch_ready (dispatch_ready),
        .wakeup         (wakeup),
        .issue          (issue),
        .issue_valid    (issue_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp) else begin
            report_failure($sformatf("[ERROR] %s: expected 0x%0h, got 0x%0h", name, exp, got));
        end
    endtask

    // Every issued packet must match the oldest expected one
    always @(negedge clk) begin
        if (issue_valid === 1'b1) begin
            issue_cycles.push_back(cycle);
            assert (expected.size() != 0) else begin
                report_failure("An operation issued while none was expected");
            end
            exp_pkt = expected.pop_front();
            check_value("issue", issue, exp_pkt);
        end
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        report_failure("Watchdog expired because the station stopped issuing");
    end

    function automatic tag_t random_tag();
        logic [31:0] r;
        r = $random(seed);
        return r[TAG_W-1:0];
    endfunction

    // Unique per test, so a broadcast wakes exactly one waiting source
    function automatic tag_t fresh_tag();
        tag_t t;
        t = random_tag();
        while (tag_used[t]) begin
            t = random_tag();
        end
        tag_used[t] = 1'b1;
        return t;
    endfunction

    function automatic rs_entry_t new_op(input logic rdy1, input logic rdy2);
        rs_entry_t   op;
        logic [31:0] r;
        r       = $random(seed);
        op.pc   = {r[PC_W-1:2], 2'b00};
        op.rd   = random_tag();
        op.src1 = rdy1 ? random_tag() : fresh_tag();
        op.src2 = rdy2 ? random_tag() : fresh_tag();
        op.rdy1 = rdy1;
        op.rdy2 = rdy2;
        return op;
    endfunction

    function automatic issue_t to_issue(input rs_entry_t op);
        issue_t pkt;
        pkt.pc   = op.pc;
        pkt.rd   = op.rd;
        pkt.src1 = op.src1;
        pkt.src2 = op.src2;
        return pkt;
    endfunction

    task automatic expect_op(input rs_entry_t op);
        expected.push_back(to_issue(op));
    endtask

    // Tasks start and end 2 ns after a rising edge
    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic dispatch_op(input rs_entry_t op);
        logic accepted;
        accepted       = 1'b0;
        dispatch       = op;
        dispatch_valid = 1'b1;
        while (!accepted) begin
            @(negedge clk);
            accepted = dispatch_ready;
            if (accepted) begin
                accept_cycle = cycle + 1;
            end
            @(posedge clk);
            #2;
        end
        dispatch_valid = 1'b0;
    endtask

    task automatic wake_tag(input tag_t tag, input int bus);
        wakeup[bus].valid = 1'b1;
        wakeup[bus].tag   = tag;
        idle(1);
        wakeup = '0;
    endtask

    task automatic wait_drain();
        while (expected.size() != 0) begin
            idle(1);
        end
        idle(12);   // Room for stray issues and head catching up
    endtask

    task automatic expect_blocked(input int n);
        repeat (n) begin
            @(negedge clk);
            check_value("dispatch_ready", dispatch_ready, 1'b0);
            @(posedge clk);
            #2;
        end
    endtask

    // Up to NUM_WAKE tags per cycle, oldest operations first
    task automatic wake_all_waiting();
        for (int i = 0; i < NUM_FILL; i += NUM_WAKE) begin
            wakeup = '0;
            for (int j = 0; j < NUM_WAKE; j++) begin
                if (i + j < NUM_FILL) begin
                    wakeup[j].valid = 1'b1;
                    wakeup[j].tag   = wait_ops[i + j].src1;
                end
            end
            idle(1);
        end
        wakeup = '0;
    endtask

    task automatic check_reset_state();
        @(negedge clk);
        check_value("issue_valid", issue_valid, 1'b0);
        check_value("dispatch_ready", dispatch_ready, 1'b1);
        @(posedge clk);
        #2;
    endtask

    task automatic issue_in_order();
        rs_entry_t ops[3];
        int        first_accept;
        issue_cycles.delete();
        for (int i = 0; i < 3; i++) begin
            ops[i] = new_op(1'b1, 1'b1);
            expect_op(ops[i]);
        end
        dispatch_op(ops[0]);
        first_accept = accept_cycle;
        dispatch_op(ops[1]);
        dispatch_op(ops[2]);
        wait_drain();
        check_value("issue_valid cycle", issue_cycles[0], first_accept + 2);
    endtask

    task automatic wake_older_late();
        rs_entry_t older;
        rs_entry_t younger;
        tag_used = '0;
        older    = new_op(1'b0, 1'b1);
        younger  = new_op(1'b1, 1'b1);
        expect_op(younger);
        dispatch_op(older);
        dispatch_op(younger);
        wait_drain();           // Older one must still be waiting here
        expect_op(older);
        wake_tag(older.src1, 2);
        wait_drain();
    endtask

    task automatic wake_at_dispatch();
        rs_entry_t op;
        tag_used = '0;
        op       = new_op(1'b0, 1'b1);
        expect_op(op);
        wakeup[1].valid = 1'b1;     // Same cycle as the acceptance
        wakeup[1].tag   = op.src1;
        dispatch_op(op);
        wakeup = '0;
        wait_drain();
    endtask

    task automatic fill_and_drain();
        tag_used = '0;
        issue_cycles.delete();
        for (int i = 0; i < NUM_FILL; i++) begin
            wait_ops[i] = new_op(1'b0, 1'b1);
            expect_op(wait_ops[i]);
        end
        late_op = new_op(1'b1, 1'b1);
        expect_op(late_op);
        for (int i = 0; i < NUM_FILL; i++) begin
            dispatch_op(wait_ops[i]);
        end
        dispatch       = late_op;
        dispatch_valid = 1'b1;
        expect_blocked(6);
        wake_tag(wait_ops[10].src1, 0);     // Slot 10 lies past the window
        expect_blocked(10);
        assert (issue_cycles.size() == 0) else begin
            report_failure("An operation outside the issue window was issued");
        end
        fork
            dispatch_op(late_op);
            wake_all_waiting();
        join
        wait_drain();
        assert (accept_cycle > issue_cycles[0]) else begin
            report_failure("Dispatch was accepted into a full station before any issue");
        end
    endtask

    task automatic flush_discards();
        rs_entry_t w0;
        rs_entry_t w1;
        rs_entry_t op;
        tag_used = '0;
        issue_cycles.delete();
        w0 = new_op(1'b0, 1'b1);
        w1 = new_op(1'b0, 1'b1);
        dispatch_op(w0);
        dispatch_op(w1);
        idle(2);
        flush = 1'b1;
        idle(1);
        flush = 1'b0;
        wakeup[0].valid = 1'b1;
        wakeup[0].tag   = w0.src1;
        wakeup[3].valid = 1'b1;
        wakeup[3].tag   = w1.src1;
        idle(1);
        wakeup = '0;
        idle(8);
        assert (issue_cycles.size() == 0) else begin
            report_failure("An operation dispatched before the flush was issued");
        end
        op = new_op(1'b1, 1'b1);
        expect_op(op);
        dispatch_op(op);
        wait_drain();
        check_value("issue_valid cycle", issue_cycles[0], accept_cycle + 2);
    endtask

    initial begin
        reset          = 1'b1;
        flush          = 1'b0;
        dispatch       = '0;
        dispatch_valid = 1'b0;
        wakeup         = '0;
        cycle          = 0;
        accept_cycle   = 0;
        tag_used       = '0;
        repeat (8) @(posedge clk);
        #2;
        reset = 1'b0;

        check_reset_state();
        issue_in_order();
        wake_older_late();
        wake_at_dispatch();
        fill_and_drain();
        flush_discards();

        $display("Testbench passed");
        $finish;
    end

endmodule

/* all.f */
rs_pkg.sv
rs_dispatch_stage.sv
rs_entry_file.sv
rs_issue_select.sv
mul_rs_top.sv
tb_mul_rs.sv

/* Makefile */
SIM       = verilator
TOP       = tb_mul_rs
FILELIST  = all.f
BUILD_DIR = obj_dir
FLAGS     = --binary --assert -Wno-fatal --top-module $(TOP) --Mdir $(BUILD_DIR)
LINTFLAGS = --lint-only --timing --assert -Wall --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(SIM) $(LINTFLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
